/* hw/collision_checker.sv */
// Registered test of the player cell against every ghost cell
`timescale 1ns/10ps
`default_nettype none

module collision_checker (
    input logic clock,
    input logic resetn,
    input logic check_en,
    input game_pkg::coord_x_t player_x,
    input game_pkg::coord_y_t player_y,
    input game_pkg::coord_x_t ghost_x [game_pkg::num_ghosts],
    input game_pkg::coord_y_t ghost_y [game_pkg::num_ghosts],
    output logic collided
);

    logic any_hit;

    // Same cell on both axes for any ghost
    always_comb begin
        any_hit = 1'b0;
        for (int g = 0; g < game_pkg::num_ghosts; g++) begin
            if ((ghost_x[g] == player_x) && (ghost_y[g] == player_y)) begin
                any_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            collided <= 1'b0;
        end else if (check_en) begin
            collided <= any_hit;                  // Held until next frame's check
        end
    end

endmodule

`default_nettype wire

/* hw/frame_sequencer.sv */
// Frame control FSM producing move, step, check and render phases plus busy and done
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer (
    input logic clock,
    input logic resetn,
    input logic start,
    input logic render_done,
    output logic move_en,
    output logic step_en,
    output logic check_en,
    output logic render_en,
    output logic busy,
    output logic done
);

    logic [game_pkg::seq_state_w-1:0] state;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            state <= game_pkg::st_idle;
            done <= 1'b0;
        end else begin
            done <= 1'b0;                         // Single cycle pulse
            case (state)
                game_pkg::st_idle: begin
                    if (start) begin
                        state <= game_pkg::st_move;
                    end
                end
                game_pkg::st_move: state <= game_pkg::st_step;
                game_pkg::st_step: state <= game_pkg::st_wait;
                game_pkg::st_wait: state <= game_pkg::st_check;   // Let ghost ROM settle
                game_pkg::st_check: state <= game_pkg::st_render;
                game_pkg::st_render: begin
                    // Renderer flags its last write, frame ends here
                    if (render_done) begin
                        state <= game_pkg::st_idle;
                        done <= 1'b1;
                    end
                end
                default: state <= game_pkg::st_idle;
            endcase
        end
    end

    // Phase strobes decoded from state
    assign move_en = (state == game_pkg::st_move);
    assign step_en = (state == game_pkg::st_step);
    assign check_en = (state == game_pkg::st_check);
    assign render_en = (state == game_pkg::st_render);
    assign busy = (state != game_pkg::st_idle);   // Low again when done fires

    // Done is strictly a pulse, frames cannot chain back to back
    a_done_pulse: assert property (@(posedge clock) disable iff (!resetn)
        done |=> !done);

    // A new move never starts straight out of rendering
    a_move_not_render: assert property (@(posedge clock) disable iff (!resetn)
        move_en |-> !$past(render_en));

endmodule

`default_nettype wire

/* hw/game_pkg.sv */
// Board and framebuffer constants, coordinate and color types, direction codes, path word union
`default_nettype none

package game_pkg;

    // Maze geometry in blocks
    localparam int board_w = 29;
    localparam int board_h = 13;
    localparam int block_px = 5;                  // Pixels per block side

    // Framebuffer
    localparam int fb_w = 160;                    // Row pitch in pixels
    localparam int fb_addr_w = 15;
    localparam int color_w = 12;
    localparam int render_writes = board_w * board_h * block_px * block_px;

    // Ghost path ROM
    localparam int path_words = 38;
    localparam int num_ghosts = 3;

    typedef logic [4:0] coord_x_t;                // Board column 0..28
    typedef logic [3:0] coord_y_t;                // Board row 0..12
    typedef logic [2:0] dir_t;
    typedef logic [fb_addr_w-1:0] fb_addr_t;
    typedef logic [color_w-1:0] color_t;

    localparam coord_x_t player_start_x = 5'd1;
    localparam coord_y_t player_start_y = 4'd1;

    // Direction codes, anything else holds position
    localparam dir_t dir_up = 3'd1;
    localparam dir_t dir_left = 3'd2;
    localparam dir_t dir_down = 3'd3;
    localparam dir_t dir_right = 3'd4;

    localparam color_t wall_color = '1;
    localparam color_t floor_color = '0;

    // Frame sequencer state codes
    localparam int seq_state_w = 3;
    localparam logic [seq_state_w-1:0] st_idle = 3'd0;
    localparam logic [seq_state_w-1:0] st_move = 3'd1;
    localparam logic [seq_state_w-1:0] st_step = 3'd2;
    localparam logic [seq_state_w-1:0] st_wait = 3'd3;   // ROM read latency
    localparam logic [seq_state_w-1:0] st_check = 3'd4;
    localparam logic [seq_state_w-1:0] st_render = 3'd5;

    // One path ROM entry, raw or split into cell fields
    typedef union packed {
        logic [10:0] raw;
        struct packed {
            coord_x_t x;                          // Bits 10..6
            coord_y_t y;                          // Bits 5..2
            logic [1:0] rsvd;                     // Unused
        } f;
    } path_word_u;

endpackage

`default_nettype wire

/* hw/game_top.sv */
// Top level joining sequencer, player mover, three ghost walkers, collision checker, renderer
`timescale 1ns/10ps
`default_nettype none

module game_top (
    input logic clock,
    input logic resetn,
    input logic start,
    input game_pkg::dir_t direction,
    output logic busy,
    output logic done,
    output game_pkg::coord_x_t player_x,
    output game_pkg::coord_y_t player_y,
    output game_pkg::coord_x_t ghost_x [game_pkg::num_ghosts],
    output game_pkg::coord_y_t ghost_y [game_pkg::num_ghosts],
    output logic collided,
    output logic fb_wren,
    output game_pkg::fb_addr_t fb_addr,
    output game_pkg::color_t fb_data
);

    // Phase strobes
    logic move_en, step_en, check_en, render_en;
    logic render_done;

    frame_sequencer frame_sequencer_i (
        .clock(clock),
        .resetn(resetn),
        .start(start),
        .render_done(render_done),
        .move_en(move_en),
        .step_en(step_en),
        .check_en(check_en),
        .render_en(render_en),
        .busy(busy),
        .done(done)
    );

    player_mover player_mover_i (
        .clock(clock),
        .resetn(resetn),
        .move_en(move_en),
        .direction(direction),
        .player_x(player_x),
        .player_y(player_y)
    );

    // Path slices 0..15, 16..27, 28..37
    ghost_path_walker #(.path_base(0), .path_len(16)) ghost_path_walker_0_i (
        .clock(clock),
        .resetn(resetn),
        .step_en(step_en),
        .ghost_x(ghost_x[0]),
        .ghost_y(ghost_y[0])
    );

    ghost_path_walker #(.path_base(16), .path_len(12)) ghost_path_walker_1_i (
        .clock(clock),
        .resetn(resetn),
        .step_en(step_en),
        .ghost_x(ghost_x[1]),
        .ghost_y(ghost_y[1])
    );

    ghost_path_walker #(.path_base(28), .path_len(10)) ghost_path_walker_2_i (
        .clock(clock),
        .resetn(resetn),
        .step_en(step_en),
        .ghost_x(ghost_x[2]),
        .ghost_y(ghost_y[2])
    );

    collision_checker collision_checker_i (
        .clock(clock),
        .resetn(resetn),
        .check_en(check_en),
        .player_x(player_x),
        .player_y(player_y),
        .ghost_x(ghost_x),
        .ghost_y(ghost_y),
        .collided(collided)
    );

    maze_renderer maze_renderer_i (
        .clock(clock),
        .resetn(resetn),
        .render_en(render_en),
        .render_done(render_done),
        .fb_wren(fb_wren),
        .fb_addr(fb_addr),
        .fb_data(fb_data)
    );

endmodule

`default_nettype wire

/* hw/ghost_path_walker.sv */
// One ghost stepping along its looping path held in the shared path ROM
`timescale 1ns/10ps
`default_nettype none

module ghost_path_walker #(
    parameter int path_base = 0,                  // First ROM entry of this path
    parameter int path_len = 16                   // Steps before wrapping
) (
    input logic clock,
    input logic resetn,
    input logic step_en,
    output game_pkg::coord_x_t ghost_x,
    output game_pkg::coord_y_t ghost_y
);

    logic [$clog2(path_len)-1:0] idx;             // Position along the path
    logic [$clog2(game_pkg::path_words)-1:0] rom_addr;
    logic [10:0] rom [game_pkg::path_words];
    game_pkg::path_word_u word;                   // Registered ROM output

    // Whole path file, only this ghost's slice is addressed
    initial begin
        $readmemh("hw/ghost_paths.hex", rom);
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            idx <= '0;
        end else if (step_en) begin
            if (idx == $bits(idx)'(path_len - 1)) begin
                idx <= '0;                        // Loop back to start of path
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    assign rom_addr = $bits(rom_addr)'(path_base) + $bits(rom_addr)'(idx);

    // Sync ROM read, new cell shows one clock after the step
    always_ff @(posedge clock) begin
        word.raw <= rom[rom_addr];
    end

    assign ghost_x = word.f.x;
    assign ghost_y = word.f.y;

    // Index never runs off the end of its slice
    a_idx_range: assert property (@(posedge clock) disable iff (!resetn)
        idx < path_len);

endmodule

`default_nettype wire

/* hw/ghost_paths.hex */
// One 11 bit path word per line, x in bits 10..6, y in bits 5..2, bits 1..0 reserved
0C0
080
044
000
004
008
004
044
084
0C4
0C8
108
104
144
140
100
514
554
594
5D7
614
618
61C
5DC
59C
55C
51C
518
2AC
2EC
32C
36C
3AC
3AA
368
328
2E8
2A8

/* hw/maze.hex */
// One maze row per line, 29 wall bits, bit n is block column n
1FFFFFFF
10000001
1ADB5B6B
12400481
16DB6DB5
10410041
177E3F77
10041001
16DB6DB5
12400481
1ADB5B6B
10000001
1FFFFFFF

/* hw/maze_renderer.sv */
// Maze ROM and block and pixel counters streaming the maze into the framebuffer
`timescale 1ns/10ps
`default_nettype none

module maze_renderer (
    input logic clock,
    input logic resetn,
    input logic render_en,
    output logic render_done,
    output logic fb_wren,
    output game_pkg::fb_addr_t fb_addr,
    output game_pkg::color_t fb_data
);

    logic [game_pkg::board_w-1:0] maze [game_pkg::board_h];   // One wall bit per block

    logic [2:0] dx, dy;                           // Pixel within block
    logic [4:0] dx_block;                         // Block column
    logic [3:0] dy_block;                         // Block row
    logic [13:0] write_cnt;                       // Writes so far this frame
    logic last_px;
    logic active;
    logic [6:0] pix_y;
    logic [7:0] pix_x;

    initial begin
        $readmemh("hw/maze.hex", maze);
    end

    assign active = render_en && !render_done;    // Stop after the final write
    assign last_px = (write_cnt == 14'(game_pkg::render_writes - 1));

    // Framebuffer pixel coordinates of the current write
    assign pix_y = 7'(dy_block * game_pkg::block_px + dy);
    assign pix_x = 8'(dx_block * game_pkg::block_px + dx);

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            dx <= '0;
            dy <= '0;
            dx_block <= '0;
            dy_block <= '0;
            write_cnt <= '0;
            fb_wren <= 1'b0;
            render_done <= 1'b0;
        end else if (active) begin
            fb_wren <= 1'b1;
            render_done <= last_px;               // Flagged alongside the last write
            write_cnt <= last_px ? '0 : write_cnt + 1'b1;
            // Pixel column innermost, then block column, pixel row, block row
            if (dx == 3'(game_pkg::block_px - 1)) begin
                dx <= '0;
                if (dx_block == 5'(game_pkg::board_w - 1)) begin
                    dx_block <= '0;
                    if (dy == 3'(game_pkg::block_px - 1)) begin
                        dy <= '0;
                        if (dy_block == 4'(game_pkg::board_h - 1)) begin
                            dy_block <= '0;       // Frame complete, rewind
                        end else begin
                            dy_block <= dy_block + 1'b1;
                        end
                    end else begin
                        dy <= dy + 1'b1;
                    end
                end else begin
                    dx_block <= dx_block + 1'b1;
                end
            end else begin
                dx <= dx + 1'b1;
            end
        end else begin
            fb_wren <= 1'b0;
            render_done <= 1'b0;
        end
    end

    // Write payload, qualified by fb_wren
    always_ff @(posedge clock) begin
        if (active) begin
            fb_addr <= game_pkg::fb_addr_t'(pix_y * game_pkg::fb_w + pix_x);
            fb_data <= maze[dy_block][dx_block] ? game_pkg::wall_color
                                                : game_pkg::floor_color;
        end
    end

    // Writes stay inside the 65 rows the maze covers
    a_addr_range: assert property (@(posedge clock) disable iff (!resetn)
        fb_wren |-> fb_addr < game_pkg::fb_w * game_pkg::board_h * game_pkg::block_px);

endmodule

`default_nettype wire

/* hw/player_mover.sv */
// Player position register stepped by direction code with board edge clamping
`timescale 1ns/10ps
`default_nettype none

module player_mover (
    input logic clock,
    input logic resetn,
    input logic move_en,
    input game_pkg::dir_t direction,
    output game_pkg::coord_x_t player_x,
    output game_pkg::coord_y_t player_y
);

    // Edge tests for the clamp
    logic at_top, at_left, at_bottom, at_right;

    assign at_top = (player_y == '0);
    assign at_left = (player_x == '0);
    assign at_bottom = (player_y == game_pkg::coord_y_t'(game_pkg::board_h - 1));
    assign at_right = (player_x == game_pkg::coord_x_t'(game_pkg::board_w - 1));

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            player_x <= game_pkg::player_start_x;
            player_y <= game_pkg::player_start_y;
        end else if (move_en) begin
            // Direction sampled on the move strobe
            case (direction)
                game_pkg::dir_up: begin
                    if (!at_top) player_y <= player_y - 1'b1;
                end
                game_pkg::dir_left: begin
                    if (!at_left) player_x <= player_x - 1'b1;
                end
                game_pkg::dir_down: begin
                    if (!at_bottom) player_y <= player_y + 1'b1;
                end
                game_pkg::dir_right: begin
                    if (!at_right) player_x <= player_x + 1'b1;
                end
                default: ;                        // Unknown code, stay put
            endcase
        end
    end

    // Player can never leave the maze
    a_on_board: assert property (@(posedge clock) disable iff (!resetn)
        (player_x < game_pkg::board_w) && (player_y < game_pkg::board_h));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module game_tb -f src.f -o game_sim \
    && ./obj_dir/game_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

/* src.f */
hw/game_pkg.sv
hw/frame_sequencer.sv
hw/player_mover.sv
hw/ghost_path_walker.sv
hw/collision_checker.sv
hw/maze_renderer.sv
hw/game_top.sv
test/game_tb.sv

/* test/game_tb.sv */
// Testbench for game_top with a frame table, reference model, write stream check and watchdog
`timescale 1ns/10ps
`default_nettype none

module game_tb;

    localparam int clk_period = 4;
    localparam int table_rows = 12;
    localparam int random_rows = 6;
    localparam int total_frames = table_rows + random_rows;
    localparam int frame_latency = 9430;          // Start edge to done edge
    localparam int poke_cycle = 3000;             // Restart attempt deep inside render
    localparam longint watchdog_ns = longint'(total_frames) * frame_latency * clk_period + 2000;

    logic clock = 1'b0;
    logic resetn;
    logic start;
    game_pkg::dir_t direction;
    logic busy, done, collided, fb_wren;
    game_pkg::coord_x_t player_x;
    game_pkg::coord_y_t player_y;
    game_pkg::coord_x_t ghost_x [game_pkg::num_ghosts];
    game_pkg::coord_y_t ghost_y [game_pkg::num_ghosts];
    game_pkg::fb_addr_t fb_addr;
    game_pkg::color_t fb_data;

    // Frame table of direction, mid-render start, expected player cell and hit
    string tbl_name [table_rows] = '{"up_from_start", "up_into_top_edge", "left_onto_ghost",
        "left_into_corner", "invalid_code_7", "down_onto_ghost", "right_onto_ghost",
        "idle_code_0", "right_open", "down_open", "idle_with_poke", "invalid_code_5"};
    game_pkg::dir_t tbl_dir [table_rows] = '{3'd1, 3'd1, 3'd2, 3'd2, 3'd7, 3'd3, 3'd4, 3'd0,
        3'd4, 3'd3, 3'd0, 3'd5};
    logic tbl_poke [table_rows] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 1, 0};
    int tbl_x [table_rows] = '{1, 1, 0, 0, 0, 0, 1, 1, 2, 2, 2, 2};
    int tbl_y [table_rows] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 2, 2, 2};
    logic tbl_hit [table_rows] = '{0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0};

    // Reference model state
    logic [game_pkg::board_w-1:0] maze_ref [game_pkg::board_h];
    logic [10:0] path_ref [game_pkg::path_words];
    int path_base_ref [game_pkg::num_ghosts] = '{0, 16, 28};
    int path_len_ref [game_pkg::num_ghosts] = '{16, 12, 10};
    int gidx [game_pkg::num_ghosts];
    int mod_x, mod_y;

    string cur_name, fail_line;
    int test_errors, pass_count, fail_count, frame_writes;
    integer seed = 32'h77c3;
    bit seen_hit, seen_miss;

    game_top game_top_i (.clock(clock), .resetn(resetn), .start(start), .direction(direction),
        .busy(busy), .done(done), .player_x(player_x), .player_y(player_y),
        .ghost_x(ghost_x), .ghost_y(ghost_y), .collided(collided), .fb_wren(fb_wren),
        .fb_addr(fb_addr), .fb_data(fb_data));

    always #(clk_period / 2) clock = ~clock;

    // Keeps the first wrong value of the running test for its result line
    task automatic record_mismatch(input string what, input int expected, input int actual);
        if (test_errors == 0) begin
            fail_line = $sformatf("Fail %s: %s expected %0d, actual %0d",
                                  cur_name, what, expected, actual);
        end
        test_errors++;
    endtask

    function automatic game_pkg::coord_x_t ghost_ref_x(input int g);
        logic [10:0] w;
        w = path_ref[path_base_ref[g] + gidx[g]];
        return w[10:6];                           // Column field
    endfunction

    function automatic game_pkg::coord_y_t ghost_ref_y(input int g);
        logic [10:0] w;
        w = path_ref[path_base_ref[g] + gidx[g]];
        return w[5:2];                            // Row field
    endfunction

    // Address of write n with pixel column fastest and block row slowest
    function automatic int write_addr(input int n);
        int dx, bx, dy, by;
        dx = n % game_pkg::block_px;
        bx = (n / game_pkg::block_px) % game_pkg::board_w;
        dy = (n / (game_pkg::block_px * game_pkg::board_w)) % game_pkg::block_px;
        by = n / (game_pkg::block_px * game_pkg::board_w * game_pkg::block_px);
        return (by * game_pkg::block_px + dy) * game_pkg::fb_w + bx * game_pkg::block_px + dx;
    endfunction

    function automatic game_pkg::color_t write_color(input int n);
        int bx, by;
        bx = (n / game_pkg::block_px) % game_pkg::board_w;
        by = n / (game_pkg::block_px * game_pkg::board_w * game_pkg::block_px);
        if (by >= game_pkg::board_h) return '0;   // No block row below the maze
        return maze_ref[by][bx] ? game_pkg::wall_color : game_pkg::floor_color;
    endfunction

    function automatic bit any_ghost_hit();
        bit hit;
        hit = 1'b0;
        for (int g = 0; g < game_pkg::num_ghosts; g++) begin
            if (ghost_ref_x(g) == mod_x && ghost_ref_y(g) == mod_y) hit = 1'b1;
        end
        return hit;
    endfunction

    // Direction rule with edge clamp and hold on unknown codes
    task automatic move_model(input game_pkg::dir_t dir);
        case (dir)
            game_pkg::dir_up: if (mod_y > 0) mod_y--;
            game_pkg::dir_left: if (mod_x > 0) mod_x--;
            game_pkg::dir_down: if (mod_y < game_pkg::board_h - 1) mod_y++;
            game_pkg::dir_right: if (mod_x < game_pkg::board_w - 1) mod_x++;
            default: ;
        endcase
    endtask

    task automatic check_cells(input bit exp_hit);
        if (player_x !== mod_x) record_mismatch("player_x", mod_x, int'(player_x));
        if (player_y !== mod_y) record_mismatch("player_y", mod_y, int'(player_y));
        for (int g = 0; g < game_pkg::num_ghosts; g++) begin
            if (ghost_x[g] !== ghost_ref_x(g)) begin
                record_mismatch($sformatf("ghost_x[%0d]", g), ghost_ref_x(g), int'(ghost_x[g]));
            end
            if (ghost_y[g] !== ghost_ref_y(g)) begin
                record_mismatch($sformatf("ghost_y[%0d]", g), ghost_ref_y(g), int'(ghost_y[g]));
            end
        end
        if (collided !== exp_hit) record_mismatch("collided", exp_hit, int'(collided));
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Pass %s", cur_name);
            pass_count++;
        end else begin
            $display("%s (%0d wrong values)", fail_line, test_errors);
            fail_count++;
        end
    endtask

    // One start pulse and an optional second start mid-render, then wait for done
    task automatic run_frame(input game_pkg::dir_t dir, input logic poke, input bit exp_hit);
        int cycles;
        frame_writes = 0;
        start = 1'b1;
        direction = dir;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles == 1) start = 1'b0;
            if (cycles == 2 && busy !== 1'b1) record_mismatch("busy", 1, int'(busy));
            if (poke && cycles == poke_cycle) begin
                start = 1'b1;                     // Must be ignored while busy
                direction = game_pkg::dir_right;
            end
            if (poke && cycles == poke_cycle + 1) start = 1'b0;
        end while (done !== 1'b1);
        if (cycles - 1 != frame_latency) record_mismatch("latency", frame_latency, cycles - 1);
        if (busy !== 1'b0) record_mismatch("busy at done", 0, int'(busy));
        if (frame_writes != game_pkg::render_writes) begin
            record_mismatch("write count", game_pkg::render_writes, frame_writes);
        end
        check_cells(exp_hit);
    endtask

    // Write stream checked in order against the address and color rule
    always @(negedge clock) begin
        if (resetn === 1'b1 && fb_wren === 1'b1) begin
            if (fb_addr !== write_addr(frame_writes)) begin
                record_mismatch($sformatf("fb_addr of write %0d", frame_writes),
                                write_addr(frame_writes), int'(fb_addr));
            end
            if (fb_data !== write_color(frame_writes)) begin
                record_mismatch($sformatf("fb_data of write %0d", frame_writes),
                                int'(write_color(frame_writes)), int'(fb_data));
            end
            frame_writes++;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, done never arrived for the running frame");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        game_pkg::dir_t dir;
        bit exp_hit;
        integer r;
        resetn = 1'b0;
        start = 1'b0;
        direction = '0;
        frame_writes = 0;
        $readmemh("hw/maze.hex", maze_ref);
        $readmemh("hw/ghost_paths.hex", path_ref);
        mod_x = 1;                                // Start cell
        mod_y = 1;
        for (int g = 0; g < game_pkg::num_ghosts; g++) gidx[g] = 0;
        repeat (10) @(negedge clock);
        resetn = 1'b1;
        repeat (2) @(negedge clock);

        cur_name = "reset";
        test_errors = 0;
        if (busy !== 1'b0) record_mismatch("busy", 0, int'(busy));
        if (done !== 1'b0) record_mismatch("done", 0, int'(done));
        if (fb_wren !== 1'b0) record_mismatch("fb_wren", 0, int'(fb_wren));
        check_cells(1'b0);
        finish_test();

        for (int i = 0; i < total_frames; i++) begin
            test_errors = 0;
            for (int g = 0; g < game_pkg::num_ghosts; g++) begin
                gidx[g] = (gidx[g] + 1) % path_len_ref[g];
            end
            if (i < table_rows) begin
                cur_name = tbl_name[i];
                dir = tbl_dir[i];
                mod_x = tbl_x[i];
                mod_y = tbl_y[i];
                exp_hit = tbl_hit[i];
            end else begin
                cur_name = $sformatf("random_%0d", i - table_rows);
                r = $random(seed);
                dir = r[2:0];
                move_model(dir);
                exp_hit = any_ghost_hit();
            end
            run_frame(dir, (i < table_rows) ? tbl_poke[i] : 1'b0, exp_hit);
            // Flag values the DUT actually showed
            if (collided === 1'b1) begin
                seen_hit = 1'b1;
            end else if (collided === 1'b0) begin
                seen_miss = 1'b1;
            end
            finish_test();
        end

        if (!(seen_hit && seen_miss)) begin
            $display("Collision flag was not exercised both set and clear");
            fail_count++;
        end
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
